/* design/tilemap_pkg.sv */
//****************************
// tile map shared types
// line config, tile attributes, mapper result, pixel word
//****************************
`default_nettype none

package tilemap_pkg;

    // layer size code, decoded from one-hot size
    typedef logic [1:0] layer_t;

    localparam layer_t LAYER_NONE = 2'd0;
    localparam layer_t LAYER_8    = 2'd1;
    localparam layer_t LAYER_16   = 2'd2;
    localparam layer_t LAYER_32   = 2'd3;

    // latched once per line
    typedef struct packed {
        logic [10:0] vline;     // map row pixel line
        logic [8:0]  buf_start; // first write address
        logic [7:0]  tile_base; // first code word in tile RAM
        layer_t      layer;
    } line_cfg_t;

    // attribute word, bits 8:0 of the second tile RAM read
    typedef struct packed {
        logic [1:0] group;
        logic       vflip;
        logic       hflip;
        logic [4:0] pal;
    } tile_attr_t;

    typedef struct packed {
        logic [3:0] offset;   // ORed into rom_addr[19:16]
        logic [3:0] mask;     // ANDed over rom_addr[19:16]
        logic       unmapped;
    } bank_map_t;

    // line buffer data word
    typedef struct packed {
        logic [1:0] group;
        logic [4:0] pal;
        logic [3:0] colour;
    } pixel_t;

    // one pixel out of four bit planes, plane 3 in the top byte
    function automatic logic [3:0] planar_pick(input logic [31:0] w, input logic hflip);
        if (hflip) begin
            return {w[24], w[16], w[8], w[0]};
        end
        return {w[31], w[23], w[15], w[7]};
    endfunction

endpackage

`default_nettype wire

/* design/line_setup.sv */
//****************************
// line setup
// latches scroll position and layer geometry on start
//****************************
`default_nettype none

module line_setup (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    start,
    input  wire                    flip,
    input  wire [8:0]              vrender,
    input  wire [2:0]              size,
    input  wire [15:0]             hpos,
    input  wire [15:0]             vpos,
    output tilemap_pkg::line_cfg_t cfg,
    output logic                   go
);
    import tilemap_pkg::*;

    layer_t      layer;
    logic [8:0]  fine;      // hpos modulo tile width
    logic [8:0]  base;
    logic [7:0]  tile_base;
    logic [10:0] vline;

    always_comb begin
        case (size)
            3'b001:  layer = LAYER_8;
            3'b010:  layer = LAYER_16;
            3'b100:  layer = LAYER_32;
            default: layer = LAYER_NONE;
        endcase
    end

    // blank area is drawn too, so the line starts before column 64
    always_comb begin
        case (layer)
            LAYER_8: begin
                fine      = {6'd0, hpos[2:0]};
                base      = 9'h038;
                tile_base = 8'h00;
            end
            LAYER_16: begin
                fine      = {5'd0, hpos[3:0]};
                base      = 9'h030;
                tile_base = 8'h80;
            end
            default: begin // 32x32 geometry when no layer is set
                fine      = {4'd0, hpos[4:0]};
                base      = 9'h020;
                tile_base = 8'hE0;
            end
        endcase
    end

    assign vline = vpos[10:0] + {2'b00, vrender ^ {1'b0, {8{flip}}}};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cfg <= '0;
            go  <= 1'b0;
        end else begin
            go <= start;
            if (start) begin
                cfg.vline     <= vline;
                cfg.buf_start <= base - fine;
                cfg.tile_base <= tile_base;
                cfg.layer     <= layer;
            end
        end
    end

endmodule

`default_nettype wire

/* design/gfx_bank_mapper.sv */
//****************************
// graphics bank mapper
// per-layer ROM offset and mask, flags codes out of range
//****************************
`default_nettype none

module gfx_bank_mapper (
    input  wire                    clk,
    input  wire                    rst,
    input  tilemap_pkg::layer_t    layer,
    input  wire [9:0]              code_hi,
    input  wire [15:0]             bank_offset,
    input  wire [15:0]             bank_mask,
    output tilemap_pkg::bank_map_t map
);
    import tilemap_pkg::*;

    logic [3:0] offset;
    logic [3:0] mask;
    logic       unmapped;

    // nibble n-1 of each bank register belongs to layer n
    always_comb begin
        case (layer)
            LAYER_8: begin
                offset = bank_offset[3:0];
                mask   = bank_mask[3:0];
            end
            LAYER_16: begin
                offset = bank_offset[7:4];
                mask   = bank_mask[7:4];
            end
            LAYER_32: begin
                offset = bank_offset[11:8];
                mask   = bank_mask[11:8];
            end
            default: begin
                offset = 4'd0;
                mask   = 4'd0;
            end
        endcase
    end

    // any top code bit that the mask drops means no ROM behind it
    assign unmapped = |(code_hi[9:6] & ~mask);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            map <= '0;
        end else begin
            map.offset   <= offset;
            map.mask     <= mask;
            map.unmapped <= unmapped;
        end
    end

endmodule

`default_nettype wire

/* design/tile_renderer.sv */
//****************************
// tile renderer
// tile RAM reads, ROM fetch and planar pixel shift
//****************************
`default_nettype none

module tile_renderer (
    input  wire                    clk,
    input  wire                    rst,
    input  tilemap_pkg::line_cfg_t cfg,
    input  wire                    go,
    input  wire                    line_end,
    input  wire [15:0]             tile_data,
    input  tilemap_pkg::bank_map_t map,
    input  wire [31:0]             rom_data,
    input  wire                    rom_ok,
    output logic [7:0]             tile_addr,
    output logic [9:0]             code_hi,
    output tilemap_pkg::layer_t    layer,
    output logic [19:0]            rom_addr,
    output logic                   rom_half,
    output logic                   rom_cs,
    output tilemap_pkg::pixel_t    pix,
    output logic                   pix_valid,
    output logic                   line_go
);
    import tilemap_pkg::*;

    localparam logic [2:0] S_IDLE    = 3'd0;
    localparam logic [2:0] S_RD_CODE = 3'd1; // code address goes into the RAM
    localparam logic [2:0] S_CODE    = 3'd2;
    localparam logic [2:0] S_ATTR    = 3'd3; // also the mapper wait
    localparam logic [2:0] S_ADDR    = 3'd4;
    localparam logic [2:0] S_WAIT    = 3'd5;
    localparam logic [2:0] S_SHIFT   = 3'd6;

    logic [2:0]  state;
    logic [15:0] code;
    tile_attr_t  attr;
    logic [31:0] shreg;     // current ROM word, shifted out a pixel per cycle
    logic [2:0]  pix_cnt;
    logic [1:0]  burst;     // ROM word index in the tile
    logic [1:0]  last_burst;
    logic [19:0] pre_addr;
    logic [19:0] tile_rom_addr;

    assign layer   = cfg.layer;
    assign code_hi = code[15:6];

    always_comb begin
        case (cfg.layer)
            LAYER_8:  last_burst = 2'd0;
            LAYER_16: last_burst = 2'd1;
            default:  last_burst = 2'd3;
        endcase
    end

    // ROM address from code and tile line, then banked
    always_comb begin
        case (cfg.layer)
            LAYER_8:  pre_addr = {1'b0, code, cfg.vline[2:0] ^ {3{attr.vflip}}};
            LAYER_16: pre_addr = {code, cfg.vline[3:0] ^ {4{attr.vflip}}};
            default:  pre_addr = {code[13:0], cfg.vline[4:0] ^ {5{attr.vflip}}, attr.hflip};
        endcase
        tile_rom_addr = (pre_addr & {map.mask, 16'hFFFF}) | {map.offset, 16'h0000};
    end

    assign pix_valid  = (state == S_SHIFT);
    assign line_go    = go && (state == S_IDLE);
    assign pix.group  = attr.group;
    assign pix.pal    = attr.pal;
    assign pix.colour = map.unmapped ? 4'hF : planar_pick(shreg, attr.hflip);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= S_IDLE;
            tile_addr <= 8'd0;
            code      <= 16'd0;
            rom_addr  <= 20'd0;
            rom_half  <= 1'b0;
            rom_cs    <= 1'b0;
            pix_cnt   <= 3'd0;
            burst     <= 2'd0;
        end else if (line_end) begin
            state  <= S_IDLE; // writer ended the line
            rom_cs <= 1'b0;
            burst  <= 2'd0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (go) begin
                        tile_addr <= cfg.tile_base;
                        burst     <= 2'd0;
                        state     <= S_RD_CODE;
                    end
                end
                S_RD_CODE: begin
                    tile_addr <= tile_addr + 8'd1; // attribute word
                    state     <= S_CODE;
                end
                S_CODE: begin
                    code      <= tile_data;
                    tile_addr <= tile_addr + 8'd1; // next tile code
                    state     <= S_ATTR;
                end
                S_ATTR: begin
                    state <= S_ADDR; // map valid next cycle
                end
                S_ADDR: begin
                    rom_addr <= tile_rom_addr;
                    rom_half <= attr.hflip;
                    rom_cs   <= 1'b1;
                    state    <= S_WAIT;
                end
                S_WAIT: begin
                    if (rom_ok) begin
                        pix_cnt  <= 3'd0;
                        rom_half <= ~rom_half; // next word is the other half
                        // 32x32 right half after two words
                        if (last_burst == 2'd3 && burst == 2'd1) begin
                            rom_addr[0] <= ~rom_addr[0];
                        end
                        state <= S_SHIFT;
                    end
                end
                S_SHIFT: begin
                    pix_cnt <= pix_cnt + 3'd1;
                    if (pix_cnt == 3'd7) begin
                        if (burst == last_burst) begin
                            burst  <= 2'd0;
                            rom_cs <= 1'b0;
                            state  <= S_RD_CODE;
                        end else begin
                            burst <= burst + 2'd1;
                            state <= S_WAIT;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // tile payload, no reset needed
    always_ff @(posedge clk) begin
        if (state == S_ATTR) begin
            attr <= tile_data[8:0];
        end
        if (state == S_WAIT && rom_ok) begin
            shreg <= rom_data;
        end else if (state == S_SHIFT) begin
            shreg <= attr.hflip ? shreg >> 1 : shreg << 1; // LSB first when flipped
        end
    end

endmodule

`default_nettype wire

/* design/line_buffer_writer.sv */
//****************************
// line buffer writer
// addresses pixels into the buffer, ends the line
//****************************
`default_nettype none

module line_buffer_writer #(
    parameter int unsigned LINE_LAST = 447
) (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 line_go,
    input  wire [8:0]           buf_start,
    input  tilemap_pkg::pixel_t pix,
    input  wire                 pix_valid,
    input  wire                 stop,
    output logic [8:0]          buf_addr,
    output tilemap_pkg::pixel_t buf_data,
    output logic                buf_wr,
    output logic                line_end,
    output logic                done
);

    logic [8:0] next_addr;  // address of the next pixel

    // last entry just written, or the line was cut short
    assign line_end = stop || (buf_wr && buf_addr == 9'(LINE_LAST));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            buf_addr  <= 9'd0;
            next_addr <= 9'd0;
            buf_wr    <= 1'b0;
            done      <= 1'b0;
        end else begin
            done   <= line_end;
            buf_wr <= 1'b0;
            if (line_end) begin
                buf_addr <= 9'd0;
            end else if (line_go) begin
                next_addr <= buf_start;
            end else if (pix_valid) begin
                buf_wr    <= 1'b1;
                buf_addr  <= next_addr;
                next_addr <= next_addr + 9'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pix_valid) begin
            buf_data <= pix;
        end
    end

endmodule

`default_nettype wire

/* design/tilemap_top.sv */
//****************************
// scroll layer line renderer
// setup, bank mapper, renderer and line buffer writer
//****************************
`default_nettype none

module tilemap_top #(
    parameter int unsigned LINE_LAST = 447
) (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 flip,
    input  wire [8:0]           vrender,
    input  wire [2:0]           size,     // one-hot, bit 0 is 8x8
    input  wire [15:0]          hpos,
    input  wire [15:0]          vpos,
    input  wire                 start,
    input  wire                 stop,
    output logic                done,
    input  wire [15:0]          bank_offset,
    input  wire [15:0]          bank_mask,
    output logic [7:0]          tile_addr,
    input  wire [15:0]          tile_data,
    output logic [19:0]         rom_addr,
    output logic                rom_half,
    output logic                rom_cs,
    input  wire [31:0]          rom_data,
    input  wire                 rom_ok,
    output logic [8:0]          buf_addr,
    output tilemap_pkg::pixel_t buf_data,
    output logic                buf_wr
);
    import tilemap_pkg::*;

    line_cfg_t cfg;
    logic      go;
    layer_t    layer;
    logic [9:0] code_hi;
    bank_map_t map;
    pixel_t    pix;
    logic      pix_valid;
    logic      line_go;
    logic      line_end;

    line_setup u_setup (
        .clk     (clk),
        .rst     (rst),
        .start   (start),
        .flip    (flip),
        .vrender (vrender),
        .size    (size),
        .hpos    (hpos),
        .vpos    (vpos),
        .cfg     (cfg),
        .go      (go)
    );

    gfx_bank_mapper u_mapper (
        .clk         (clk),
        .rst         (rst),
        .layer       (layer),
        .code_hi     (code_hi),
        .bank_offset (bank_offset),
        .bank_mask   (bank_mask),
        .map         (map)
    );

    tile_renderer u_render (
        .clk       (clk),
        .rst       (rst),
        .cfg       (cfg),
        .go        (go),
        .line_end  (line_end),
        .tile_data (tile_data),
        .map       (map),
        .rom_data  (rom_data),
        .rom_ok    (rom_ok),
        .tile_addr (tile_addr),
        .code_hi   (code_hi),
        .layer     (layer),
        .rom_addr  (rom_addr),
        .rom_half  (rom_half),
        .rom_cs    (rom_cs),
        .pix       (pix),
        .pix_valid (pix_valid),
        .line_go   (line_go)
    );

    line_buffer_writer #(
        .LINE_LAST (LINE_LAST)
    ) u_writer (
        .clk       (clk),
        .rst       (rst),
        .line_go   (line_go),
        .buf_start (cfg.buf_start),
        .pix       (pix),
        .pix_valid (pix_valid),
        .stop      (stop),
        .buf_addr  (buf_addr),
        .buf_data  (buf_data),
        .buf_wr    (buf_wr),
        .line_end  (line_end),
        .done      (done)
    );

endmodule

`default_nettype wire

/* sim/clk_gen.sv */
//****************************
// clock and reset source
// free running clock, reset held two cycles
//****************************
`default_nettype none

module clk_gen #(
    parameter real PERIOD = 8.0
) (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2.0) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk); // release away from the active edge
        rst = 1'b0;
    end

endmodule

`default_nettype wire

/* sim/tilemap_tb.sv */
//****************************
// tile map line renderer testbench
// tile RAM and ROM models, reference pixels, line checks
//****************************
`default_nettype none

module tilemap_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import tilemap_pkg::*;

    localparam int LINE_LAST = 447;
    localparam int TIMEOUT   = 5000; // cycles per wait

    logic        clk;
    logic        rst;
    logic        flip = 1'b0;
    logic [8:0]  vrender = 9'd0;
    logic [2:0]  size = 3'b001;
    logic [15:0] hpos = 16'd0;
    logic [15:0] vpos = 16'd0;
    logic        start = 1'b0;
    logic        stop = 1'b0;
    logic [15:0] bank_offset = 16'h0000;
    logic [15:0] bank_mask = 16'hFFFF;
    logic [15:0] tile_data = 16'd0;
    logic [31:0] rom_data;
    logic        rom_ok = 1'b0;
    logic        done;
    logic [7:0]  tile_addr;
    logic [19:0] rom_addr;
    logic        rom_half;
    logic        rom_cs;
    logic [8:0]  buf_addr;
    pixel_t      buf_data;
    logic        buf_wr;

    logic [15:0] tile_ram [256];
    logic [1:0]  rom_gap = 2'd0;
    int          seed = 42561;
    int          rom_seed = 42561;

    // current line, as the reference sees it
    string       t_name = "none";
    int          t_layer = 1;
    int          t_tw = 8;
    logic [7:0]  t_tbase = 8'd0;
    logic [8:0]  t_first = 9'd0;
    logic [10:0] t_vline = 11'd0;
    logic        armed = 1'b0;
    logic        hung = 1'b0;
    logic [8:0]  exp_addr = 9'd0;
    logic [8:0]  first_addr = 9'd0;
    logic [8:0]  last_addr = 9'd0;
    int          wr_count = 0;
    int          done_count = 0;
    int          err_count = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    clk_gen #(.PERIOD(8.0)) u_clk (.clk(clk), .rst(rst));

    tilemap_top #(
        .LINE_LAST (LINE_LAST)
    ) uut (
        .clk         (clk),
        .rst         (rst),
        .flip        (flip),
        .vrender     (vrender),
        .size        (size),
        .hpos        (hpos),
        .vpos        (vpos),
        .start       (start),
        .stop        (stop),
        .done        (done),
        .bank_offset (bank_offset),
        .bank_mask   (bank_mask),
        .tile_addr   (tile_addr),
        .tile_data   (tile_data),
        .rom_addr    (rom_addr),
        .rom_half    (rom_half),
        .rom_cs      (rom_cs),
        .rom_data    (rom_data),
        .rom_ok      (rom_ok),
        .buf_addr    (buf_addr),
        .buf_data    (buf_data),
        .buf_wr      (buf_wr)
    );

    // graphics ROM contents, a hash of address and half
    function automatic logic [31:0] rom_word(input logic [19:0] addr, input logic half);
        logic [31:0] h;
        h = {12'd0, addr} * 32'h9E37_79B1;
        h = h ^ {16'h0, addr[19:4]} ^ (half ? 32'hC3A5_5A3C : 32'h0);
        return h ^ (h >> 13);
    endfunction

    // expected buffer word for pixel p of the line
    function automatic pixel_t ref_pixel(input int p);
        int          k;
        int          q;
        int          j;
        int          i;
        logic [7:0]  idx;
        logic [15:0] code;
        tile_attr_t  a;
        logic [4:0]  lines;
        logic [3:0]  nmask;
        logic [3:0]  noff;
        logic [19:0] addr;
        logic [31:0] w;
        pixel_t      px;
        k = p / t_tw;
        q = p % t_tw;
        j = q / 8; // ROM word within the tile
        i = q % 8;
        idx = t_tbase + 8'(2 * k);
        code = tile_ram[idx];
        a = tile_ram[idx + 8'd1][8:0];
        lines = t_vline[4:0] ^ {5{a.vflip}};
        nmask = bank_mask[4 * (t_layer - 1) +: 4];
        noff = bank_offset[4 * (t_layer - 1) +: 4];
        case (t_layer)
            1:       addr = {1'b0, code, lines[2:0]};
            2:       addr = {code, lines[3:0]};
            default: addr = {code[13:0], lines, a.hflip ^ (j >= 2)};
        endcase
        addr[19:16] = (addr[19:16] & nmask) | noff;
        w = rom_word(addr, a.hflip ^ 1'(j & 1));
        px.group = a.group;
        px.pal = a.pal;
        if (|(code[15:12] & ~nmask)) begin
            px.colour = 4'hF; // no ROM behind this code
        end else if (a.hflip) begin
            px.colour = {w[24 + i], w[16 + i], w[8 + i], w[i]};
        end else begin
            px.colour = {w[31 - i], w[23 - i], w[15 - i], w[7 - i]};
        end
        return px;
    endfunction

    // registered tile RAM read
    always @(posedge clk) begin
        tile_data <= tile_ram[tile_addr];
    end

    assign rom_data = rom_word(rom_addr, rom_half);

    always @(negedge clk) begin
        if (!rom_cs) begin
            rom_ok  <= 1'b0;
            rom_gap <= 2'($random(rom_seed));
        end else if (rom_gap == 2'd0) begin
            rom_ok  <= 1'b1;
            rom_gap <= 2'($random(rom_seed)); // gap before the next word
        end else begin
            rom_ok  <= 1'b0;
            rom_gap <= rom_gap - 2'd1;
        end
    end

    // every buffer write against the reference
    always @(negedge clk) begin
        pixel_t want;
        if (buf_wr) begin
            if (!armed) begin
                $display("%s: buf_wr to %h with no line in progress", t_name, buf_addr);
                err_count++;
            end else begin
                if (wr_count == 0) begin
                    first_addr = buf_addr;
                end
                want = ref_pixel(int'(exp_addr) - int'(t_first));
                if (buf_addr !== exp_addr) begin
                    $display("FAIL %s: buf_addr expected %h actual %h", t_name, exp_addr, buf_addr);
                    err_count++;
                end
                if (buf_data !== want) begin
                    $display("FAIL %s: buf_data at %h expected %h actual %h",
                             t_name, exp_addr, want, buf_data);
                    err_count++;
                end
                last_addr = buf_addr;
                exp_addr = exp_addr + 9'd1;
            end
            wr_count++;
        end
        if (done) begin
            done_count++;
            armed = 1'b0;
        end
    end

    task automatic finish_test(input string name, input int errs_before);
        tests_run++;
        if (err_count != errs_before) begin
            tests_failed++;
        end
        $display("test %s: %0d writes, %0d errors", name, wr_count, err_count - errs_before);
    endtask

    task automatic check_idle();
        int cycles;
        int errs_before;
        errs_before = err_count;
        t_name = "reset_idle";
        cycles = 0;
        while (rst !== 1'b0 && cycles < 100) begin
            @(negedge clk);
            cycles++;
        end
        if (rst !== 1'b0) begin
            $display("reset_idle: reset was never released");
            err_count++;
            hung = 1'b1;
        end
        repeat (20) begin
            @(negedge clk);
            if (done !== 1'b0 || buf_wr !== 1'b0 || rom_cs !== 1'b0) begin
                $display("reset_idle: outputs active before start (done %b buf_wr %b rom_cs %b)",
                         done, buf_wr, rom_cs);
                err_count++;
            end
        end
        finish_test("reset_idle", errs_before);
    endtask

    task automatic run_line(input string name, input logic f, input logic [2:0] sz,
                            input logic [15:0] hp, input logic [15:0] vp,
                            input logic [15:0] attr_set, input int stop_at);
        int         n;
        int         cycles;
        int         errs_before;
        logic [8:0] base;
        if (hung) begin
            return;
        end
        errs_before = err_count;
        @(negedge clk);
        for (n = 0; n < 256; n++) begin
            tile_ram[n] = 16'($random(seed));
            if (n % 2 == 1) begin
                tile_ram[n] = tile_ram[n] | attr_set; // attribute words sit at odd addresses
            end
        end
        flip = f;
        size = sz;
        hpos = hp;
        vpos = vp;
        vrender = 9'($random(seed));
        t_layer = sz[0] ? 1 : (sz[1] ? 2 : 3);
        t_tw = 8 << (t_layer - 1);
        base = (t_layer == 1) ? 9'h038 : ((t_layer == 2) ? 9'h030 : 9'h020);
        t_tbase = (t_layer == 1) ? 8'h00 : ((t_layer == 2) ? 8'h80 : 8'hE0);
        t_first = base - 9'(hp & 16'(t_tw - 1));
        t_vline = vp[10:0] + {2'b00, f ? {vrender[8], ~vrender[7:0]} : vrender};
        t_name = name;
        wr_count = 0;
        done_count = 0;
        exp_addr = t_first;
        armed = 1'b1;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        if (stop_at >= 0) begin
            cycles = 0;
            while (wr_count < stop_at && cycles < TIMEOUT) begin
                @(posedge clk);
                cycles++;
            end
            if (wr_count < stop_at) begin
                $display("%s: only %0d writes before the stop point", name, wr_count);
                err_count++;
            end
            @(negedge clk);
            stop = 1'b1;
            @(negedge clk);
            stop = 1'b0;
            if (done !== 1'b1 || buf_wr !== 1'b0) begin
                $display("%s: done did not pulse right after stop (done %b buf_wr %b)",
                         name, done, buf_wr);
                err_count++;
            end
        end
        cycles = 0;
        while (done_count == 0 && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (done_count == 0) begin
            $display("%s: no done within %0d cycles", name, TIMEOUT);
            err_count++;
            hung = 1'b1;
        end else begin
            repeat (30) @(negedge clk); // quiet time, stray writes get caught
            if (done_count != 1) begin
                $display("FAIL %s: done pulses expected 1 actual %0d", name, done_count);
                err_count++;
            end
            if (stop_at < 0) begin
                if (wr_count != LINE_LAST - int'(t_first) + 1) begin
                    $display("FAIL %s: writes expected %0d actual %0d",
                             name, LINE_LAST - int'(t_first) + 1, wr_count);
                    err_count++;
                end
                if (first_addr != t_first) begin
                    $display("FAIL %s: first address expected %h actual %h",
                             name, t_first, first_addr);
                    err_count++;
                end
                if (last_addr != 9'(LINE_LAST)) begin
                    $display("FAIL %s: last address expected %h actual %h",
                             name, 9'(LINE_LAST), last_addr);
                    err_count++;
                end
            end
            if (rom_cs) begin
                $display("%s: rom_cs still high after the line ended", name);
                err_count++;
            end
        end
        finish_test(name, errs_before);
    endtask

    initial begin
        check_idle();
        run_line("line_8x8", 1'b0, 3'b001, 16'h0000, 16'($random(seed)), 16'h0, -1);
        run_line("line_16x16", 1'b0, 3'b010, 16'($random(seed)), 16'($random(seed)), 16'h0, -1);
        run_line("line_32x32", 1'b0, 3'b100, 16'($random(seed)), 16'($random(seed)), 16'h0, -1);
        run_line("flip_screen_16x16", 1'b1, 3'b010, 16'($random(seed)), 16'($random(seed)),
                 16'h0, -1);
        run_line("flip_attr_32x32", 1'b1, 3'b100, 16'($random(seed)), 16'($random(seed)),
                 16'h0060, -1); // hflip and vflip on every tile
        run_line("stop_mid_line", 1'b0, 3'b010, 16'($random(seed)), 16'($random(seed)),
                 16'h0, 100);
        @(negedge clk);
        bank_mask = 16'hFFF3; // layer 1 keeps two bank bits
        bank_offset = 16'h0008;
        run_line("bank_map_8x8", 1'b0, 3'b001, 16'($random(seed)), 16'($random(seed)),
                 16'h0, -1);
        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, err_count);
        if (err_count == 0 && !hung) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tilemap_top.f */
design/tilemap_pkg.sv
design/line_setup.sv
design/gfx_bank_mapper.sv
design/tile_renderer.sv
design/line_buffer_writer.sv
design/tilemap_top.sv
sim/clk_gen.sv
sim/tilemap_tb.sv

/* Bender.yml */
package:
  name: tilemap

sources:
  - design/tilemap_pkg.sv
  - design/line_setup.sv
  - design/gfx_bank_mapper.sv
  - design/tile_renderer.sv
  - design/line_buffer_writer.sv
  - design/tilemap_top.sv
  - target: simulation
    files:
      - sim/clk_gen.sv
      - sim/tilemap_tb.sv
